// ==== compile.f ====
+incdir+verilog
+incdir+tb
verilog/cur_blk_pkg.sv
verilog/cur_blk_bank_if.sv
verilog/cur_blk_loader.sv
verilog/cur_blk_line_store.sv
verilog/cur_blk_read_port.sv
verilog/cur_blk_top.sv
tb/tb_cur_blk.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the current-block buffer testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f compile.f \
  --top-module tb_cur_blk \
  -Mdir obj_dir

./obj_dir/Vtb_cur_blk | tee sim.log

# the log decides, not the exit code of the simulation
if grep -q 'All tests passed!' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== tb/tb_cur_blk_tasks.svh ====
// ***********************************************************
// directed tests of the current-block buffer
// reset, continuous and gapped loads, row and block reads,
// start pulse during a running load
// ***********************************************************

`ifndef TB_CUR_BLK_TASKS_SVH
`define TB_CUR_BLK_TASKS_SVH

// one block load of fresh data, optionally with a second start mid-load
task automatic run_load(input logic gapped, input logic restart);
  int   cyc;
  int   done_base;
  logic seen;
  @(negedge clk);
  fill_ref();
  gap_mode  = gapped;
  beat_base = beats;
  done_base = dones;
  @(posedge clk);
  start_i <= 1'b1;
  cyc  = 0;
  seen = 1'b0;
  while (!seen && cyc < LOAD_LIMIT) begin
    @(posedge clk);
    start_i <= restart && (cyc == 300);   // well inside the load
    @(negedge clk);
    seen = done_o;
    cyc++;
  end
  assert (seen) else begin
    $display("done_o did not pulse within %0d cycles of the start", LOAD_LIMIT);
    test_errs++;
  end
  check_val("pinc_o", 256'(pinc_o), '0);
  repeat (4) @(negedge clk);              // room for a second done pulse
  check_val("pinc_o beats", 256'(beats - beat_base), 256'(BEATS));
  check_val("done_o pulses", 256'(dones - done_base), 256'(1));
endtask

task automatic test_reset();
  for (int c = 0; c < RESET_CYCLES + 2; c++) begin
    if (c == RESET_CYCLES) begin
      @(posedge clk);
      rst_n_i <= 1'b1;    // two more idle cycles after release
    end
    @(negedge clk);
    check_val("pinc_o", 256'(pinc_o), '0);
    check_val("done_o", 256'(done_o), '0);
    check_val("rd_data_o", rd_data_o, '0);
  end
  end_test("reset state");
endtask

task automatic test_load_continuous();
  run_load(1'b0, 1'b0);
  for (int l = 0; l < LUMA; l++) begin
    queue_read(1'b0, 1'b0, l, 0);
  end
  issue_reads();
  end_test("continuous load, luma rows");
endtask

// stalls must not drop or repeat a beat
task automatic test_load_gapped();
  run_load(1'b1, 1'b0);
  for (int l = 0; l < LINES - LUMA; l++) begin
    queue_read(1'b0, 1'b1, l, 0);
  end
  issue_reads();
  end_test("gapped load, chroma rows");
endtask

task automatic test_block_reads();
  for (int p = 0; p < 2; p++) begin
    for (int g = 0; g < LINES / 4; g++) begin
      for (int s = 0; s < 4; s++) begin
        // second pass sets the low line bits to 1, 2 or 3
        queue_read(1'b1, g >= LUMA / 4, (g * 4) % LUMA + p * ((g + s) % 3 + 1), s);
      end
    end
  end
  issue_reads();
  end_test("block reads");
endtask

task automatic test_restart_ignored();
  run_load(1'b0, 1'b1);
  for (int l = 0; l < LINES; l++) begin
    queue_read(1'b0, l >= LUMA, l % LUMA, 0);
  end
  issue_reads();
  end_test("start during load");
endtask

`endif

// ==== tb/tb_cur_blk.sv ====
// ***********************************************************
// testbench of the current-block pixel buffer
// clock, reset, DUT, pixel stream model, read helpers,
// watchdog and result summary
// ***********************************************************

`timescale 1ns/1ps

`include "cur_blk_cfg.svh"

module tb_cur_blk;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 16;
  localparam int LUMA         = `CUR_BLK_LUMA_LINES;
  localparam int LINES        = LUMA + `CUR_BLK_CHROMA_LINES;
  localparam int BEATS        = LINES * `CUR_BLK_BANKS;   // 768 per block
  localparam int GAP_LOAD     = 2 * BEATS + 8;            // valid high half the time
  localparam int LOAD_LIMIT   = 2 * GAP_LOAD;
  // luma rows, chroma rows, two block passes, all rows, batch overhead
  localparam int READS        = 128 + 64 + 2 * 192 + LINES + 32;
  localparam int WATCHDOG     = (RESET_CYCLES + 2 * GAP_LOAD + READS) * 3 / 2;

  logic               clk;
  logic               rst_n_i;
  logic               start_i;
  logic               pvalid_i = 1'b0;
  cur_blk_pkg::seg_t  pdata_i  = '0;
  logic               rd_en_i;
  logic               rd_blk_i;
  logic               rd_chroma_i;
  logic [6:0]         rd_line_i;
  logic [1:0]         rd_seg_i;
  logic               done_o;
  logic               pinc_o;
  cur_blk_pkg::line_t rd_data_o;

  int                 seed = 32'h32068861;
  cur_blk_pkg::line_t ref_mem [LINES];    // reference block, natural order
  logic               gap_mode = 1'b0;
  logic [31:0]        stream_rnd;
  int                 beats = 0;          // accepted beats since time 0
  int                 dones = 0;
  int                 beat_base = 0;      // beats before the current load
  logic [10:0]        req_q [$];          // {blk, chroma, line, seg}
  cur_blk_pkg::line_t exp_q [$];
  int                 test_errs = 0;
  int                 n_pass = 0;
  int                 n_fail = 0;

  cur_blk_top i_cur_blk_top (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .start_i     (start_i),
    .done_o      (done_o),
    .pinc_o      (pinc_o),
    .pvalid_i    (pvalid_i),
    .pdata_i     (pdata_i),
    .rd_en_i     (rd_en_i),
    .rd_blk_i    (rd_blk_i),
    .rd_chroma_i (rd_chroma_i),
    .rd_line_i   (rd_line_i),
    .rd_seg_i    (rd_seg_i),
    .rd_data_o   (rd_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ***********************************************************
  // stream model
  // ***********************************************************

  // answers pinc_o with the beats of ref_mem in line order
  always @(posedge clk) begin
    if (pinc_o && pvalid_i) begin
      beats = beats + 1;
    end
    if (done_o) begin
      dones = dones + 1;
    end
    if (gap_mode) begin
      stream_rnd = $random(seed);
      pvalid_i <= stream_rnd[0];
    end else begin
      pvalid_i <= 1'b1;
    end
    pdata_i <= beat_seg(beats - beat_base);
  end

  // beat b is segment b mod 4 of line b / 4
  function automatic cur_blk_pkg::seg_t beat_seg(input int b);
    if (b >= BEATS) begin
      return '0;
    end
    return ref_mem[b / 4][b % 4];
  endfunction

  task automatic fill_ref();
    logic [255:0] flat;
    for (int l = 0; l < LINES; l++) begin
      for (int w = 0; w < 8; w++) begin
        flat[w*32 +: 32] = $random(seed);
      end
      ref_mem[l] = flat;
    end
  endtask

  // ***********************************************************
  // checks and reads
  // ***********************************************************

  task automatic check_val(input string name, input logic [255:0] act,
                           input logic [255:0] exp);
    assert (act === exp) else begin
      $display("error: %s expected %0h actual %0h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic end_test(input string name);
    if (test_errs == 0) begin
      n_pass++;
      $display("test %s: ok", name);
    end else begin
      n_fail++;
      $display("test %s: %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  // expected value straight from the reference block
  task automatic queue_read(input logic blk, input logic chroma, input int line,
                            input int seg);
    cur_blk_pkg::line_t exp;
    int                 base;
    base = (chroma ? LUMA : 0) + line;
    if (blk) begin
      base = base - line % 4;             // group starts on a multiple of 4
      for (int k = 0; k < 4; k++) begin
        exp[k] = ref_mem[base + k][seg];  // line L+k in slot k
      end
    end else begin
      exp = ref_mem[base];
    end
    req_q.push_back({blk, chroma, 7'(line), 2'(seg)});
    exp_q.push_back(exp);
  endtask

  // back to back reads, each result checked one cycle after its strobe
  task automatic issue_reads();
    int n;
    n = req_q.size();
    for (int i = 0; i <= n; i++) begin
      @(posedge clk);
      rd_en_i <= (i < n);
      if (i < n) begin
        {rd_blk_i, rd_chroma_i, rd_line_i, rd_seg_i} <= req_q[i];
      end
      if (i > 0) begin
        @(negedge clk);
        check_val($sformatf("rd_data_o req %h", req_q[i-1]), rd_data_o, exp_q[i-1]);
      end
    end
    repeat (2) @(negedge clk);
    check_val("rd_data_o held", rd_data_o, exp_q[n-1]);   // no strobe, no change
    req_q.delete();
    exp_q.delete();
  endtask

  `include "tb_cur_blk_tasks.svh"

  initial begin
    rst_n_i     = 1'b0;
    start_i     = 1'b0;
    rd_en_i     = 1'b0;
    rd_blk_i    = 1'b0;
    rd_chroma_i = 1'b0;
    rd_line_i   = '0;
    rd_seg_i    = '0;
    test_reset();
    test_load_continuous();
    test_load_gapped();
    test_block_reads();
    test_restart_ignored();
    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // two gapped loads plus all reads, with half again as margin
  initial begin
    #(WATCHDOG * CLK_PERIOD);
    $display("timeout, the tests did not finish within %0d cycles", WATCHDOG);
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== verilog/cur_blk_bank_if.sv ====
// ***********************************************************
// bank bus between loader, line store and read port
// line writes in, per-bank addresses in, raw segments out
// ***********************************************************

`timescale 1ns/1ps

`include "cur_blk_cfg.svh"

interface cur_blk_bank_if;

  // write side, one natural-order line per strobe
  logic                    wr_en;
  cur_blk_pkg::line_addr_t wr_addr;
  cur_blk_pkg::line_t      wr_line;

  // read side, every bank gets its own line address
  logic                    rd_en;
  cur_blk_pkg::line_addr_t rd_addr [`CUR_BLK_BANKS];
  cur_blk_pkg::seg_t       rd_seg  [`CUR_BLK_BANKS];  // raw, still rotated

  modport loader (
    output wr_en,
    output wr_addr,
    output wr_line
  );

  modport reader (
    output rd_en,
    output rd_addr,
    input  rd_seg
  );

  modport store (
    input  wr_en,
    input  wr_addr,
    input  wr_line,
    input  rd_en,
    input  rd_addr,
    output rd_seg
  );

endinterface

// ==== verilog/cur_blk_cfg.svh ====
// ***********************************************************
// configuration macros of the current-block pixel buffer
// pixel width, segment size, bank count and line counts
// ***********************************************************

`ifndef CUR_BLK_CFG_SVH
`define CUR_BLK_CFG_SVH

// bits per pixel
`define CUR_BLK_PIXEL_WIDTH   8

// pixels per input beat, also pixels per bank segment
`define CUR_BLK_SEG_PIXELS    8

// banks, one segment of each line per bank
`define CUR_BLK_BANKS         4

`define CUR_BLK_LUMA_LINES    128   // luma part of the block
`define CUR_BLK_CHROMA_LINES  64    // chroma part, stored after luma

// stored line address, covers all 192 lines
`define CUR_BLK_ADDR_WIDTH    8

`endif

// ==== verilog/cur_blk_line_store.sv ====
// ***********************************************************
// bank store of the current-block buffer
// four segment memories of 192 lines, rotated write
// placement, registered read per bank
// ***********************************************************

`timescale 1ns/1ps

`include "cur_blk_cfg.svh"

module cur_blk_line_store (
  input  logic         clk,
  cur_blk_bank_if.store bank_if
);

  localparam int unsigned DEPTH = `CUR_BLK_LUMA_LINES + `CUR_BLK_CHROMA_LINES;

  // one memory per bank, one segment per line
  cur_blk_pkg::seg_t mem      [`CUR_BLK_BANKS][DEPTH];
  cur_blk_pkg::seg_t wr_seg   [`CUR_BLK_BANKS];   // write data per bank
  cur_blk_pkg::seg_t rd_seg_r [`CUR_BLK_BANKS];

  // ***********************************************************
  // write rotation
  // ***********************************************************

  // segment s of the line goes to bank (s + addr) mod 4
  always_comb begin
    wr_seg = '{default: '0};
    for (int s = 0; s < `CUR_BLK_BANKS; s++) begin
      wr_seg[cur_blk_pkg::bank_of_seg(cur_blk_pkg::bank_idx_t'(s), bank_if.wr_addr)] =
        bank_if.wr_line[s];
    end
  end

  // ***********************************************************
  // bank memories
  // ***********************************************************

  always_ff @(posedge clk) begin
    for (int b = 0; b < `CUR_BLK_BANKS; b++) begin
      if (bank_if.wr_en) begin
        mem[b][bank_if.wr_addr] <= wr_seg[b];
      end
      // each bank follows its own address
      if (bank_if.rd_en) begin
        rd_seg_r[b] <= mem[b][bank_if.rd_addr[b]];
      end
    end
  end

  // raw bank order, the read port undoes the rotation
  assign bank_if.rd_seg = rd_seg_r;

endmodule

// ==== verilog/cur_blk_loader.sv ====
// ***********************************************************
// load sequencer of the current-block buffer
// requests beats, assembles lines of four segments,
// writes each line and pulses done after the last one
// ***********************************************************

`timescale 1ns/1ps

`include "cur_blk_cfg.svh"

module cur_blk_loader (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              start_i,    // one-cycle start pulse
  input  logic              pvalid_i,   // beat strobe from the stream
  input  cur_blk_pkg::seg_t pdata_i,    // 8 pixels per beat
  output logic              pinc_o,     // beat request
  output logic              done_o,     // block loaded
  cur_blk_bank_if.loader    bank_if
);

  localparam int unsigned LAST_LINE = `CUR_BLK_LUMA_LINES + `CUR_BLK_CHROMA_LINES - 1;
  localparam int unsigned LAST_BEAT = `CUR_BLK_BANKS - 1;

  logic                    busy;       // load running, start is ignored
  cur_blk_pkg::bank_idx_t  beat_cnt;   // segment within the line
  cur_blk_pkg::line_addr_t line_cnt;   // line being assembled
  cur_blk_pkg::line_t      line_asm;
  logic                    wr_en_r;

  logic beat_acc;
  logic line_end;
  logic last_line;

  assign beat_acc  = pinc_o & pvalid_i;
  assign line_end  = beat_acc && (beat_cnt == cur_blk_pkg::bank_idx_t'(LAST_BEAT));
  assign last_line = (line_cnt == cur_blk_pkg::line_addr_t'(LAST_LINE));

  // ***********************************************************
  // control
  // ***********************************************************

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy     <= 1'b0;
      pinc_o   <= 1'b0;
      beat_cnt <= '0;
      line_cnt <= '0;
      wr_en_r  <= 1'b0;
      done_o   <= 1'b0;
    end else begin
      wr_en_r <= line_end;                 // write one cycle after 4th beat
      done_o  <= wr_en_r && last_line;

      if (start_i && !busy) begin
        busy     <= 1'b1;
        pinc_o   <= 1'b1;
        beat_cnt <= '0;
        line_cnt <= '0;
      end else begin
        if (beat_acc) begin
          beat_cnt <= beat_cnt + 1'b1;
        end
        // stop requesting once the 768th beat is in
        if (line_end && last_line) begin
          pinc_o <= 1'b0;
        end
        if (wr_en_r) begin
          line_cnt <= line_cnt + 1'b1;
        end
        if (wr_en_r && last_line) begin
          busy <= 1'b0;                    // load ends with the done pulse
        end
      end
    end
  end

  // ***********************************************************
  // line assembly
  // ***********************************************************

  // the write cycle still sees the full line, the next beat lands at its end
  always_ff @(posedge clk) begin
    if (beat_acc) begin
      line_asm[beat_cnt] <= pdata_i;
    end
  end

  assign bank_if.wr_en   = wr_en_r;
  assign bank_if.wr_addr = line_cnt;       // luma 0..127, chroma 128..191
  assign bank_if.wr_line = line_asm;

endmodule

// ==== verilog/cur_blk_pkg.sv ====
// ***********************************************************
// shared types of the current-block pixel buffer
// pixel, segment, line and address types, bank rotation
// ***********************************************************

`include "cur_blk_cfg.svh"

package cur_blk_pkg;

  // one pixel
  typedef logic [`CUR_BLK_PIXEL_WIDTH-1:0] pixel_t;

  // one segment, pixel 0 in the lowest byte
  typedef pixel_t [`CUR_BLK_SEG_PIXELS-1:0] seg_t;

  // one natural-order line, segment 0 lowest
  typedef seg_t [`CUR_BLK_BANKS-1:0] line_t;

  // stored line address
  typedef logic [`CUR_BLK_ADDR_WIDTH-1:0] line_addr_t;

  // bank number, also the segment index within a line
  typedef logic [$clog2(`CUR_BLK_BANKS)-1:0] bank_idx_t;

  // ***********************************************************
  // bank rotation
  // ***********************************************************

  // segment s of line L lives in bank (s + L) mod 4
  function automatic bank_idx_t bank_of_seg(
    input bank_idx_t  seg,
    input line_addr_t line
  );
    return seg + bank_idx_t'(line);   // only the low line bits count
  endfunction

endpackage

// ==== verilog/cur_blk_read_port.sv ====
// ***********************************************************
// read port of the current-block buffer
// row or block request to per-bank addresses,
// de-rotation of the bank data one cycle later
// ***********************************************************

`timescale 1ns/1ps

`include "cur_blk_cfg.svh"

module cur_blk_read_port (
  input  logic                                    clk,
  input  logic                                    rst_n_i,
  input  logic                                    rd_en_i,
  input  logic                                    rd_blk_i,     // 1: 4-line block, 0: row
  input  logic                                    rd_chroma_i,
  input  logic [$clog2(`CUR_BLK_LUMA_LINES)-1:0]  rd_line_i,
  input  cur_blk_pkg::bank_idx_t                  rd_seg_i,     // segment of a block read
  output cur_blk_pkg::line_t                      rd_data_o,
  cur_blk_bank_if.reader                          bank_if
);

  cur_blk_pkg::line_addr_t row_addr;
  cur_blk_pkg::line_addr_t blk_addr;               // row address rounded down to 4
  cur_blk_pkg::line_addr_t rd_addr_c [`CUR_BLK_BANKS];

  logic                    vld_r;   // a read has completed since reset
  logic                    blk_r;
  cur_blk_pkg::bank_idx_t  lo_r;    // low line bits of a row read
  cur_blk_pkg::bank_idx_t  seg_r;
  cur_blk_pkg::line_t      derot;

  // chroma lines sit above the luma lines
  assign row_addr = (rd_chroma_i ? cur_blk_pkg::line_addr_t'(`CUR_BLK_LUMA_LINES) : '0) +
                    cur_blk_pkg::line_addr_t'(rd_line_i);
  assign blk_addr = {row_addr[`CUR_BLK_ADDR_WIDTH-1:2], 2'b00};

  // ***********************************************************
  // bank addresses
  // ***********************************************************

  always_comb begin
    cur_blk_pkg::line_addr_t blk_line;
    blk_line = blk_addr;
    for (int b = 0; b < `CUR_BLK_BANKS; b++) begin
      rd_addr_c[b] = row_addr;     // row read, same line everywhere
    end
    if (rd_blk_i) begin
      // line L+k hands out segment rd_seg from its own bank
      for (int k = 0; k < `CUR_BLK_BANKS; k++) begin
        blk_line = blk_addr + cur_blk_pkg::line_addr_t'(k);
        rd_addr_c[cur_blk_pkg::bank_of_seg(rd_seg_i, blk_line)] = blk_line;
      end
    end
  end

  assign bank_if.rd_en   = rd_en_i;
  assign bank_if.rd_addr = rd_addr_c;

  // ***********************************************************
  // request tracking and de-rotation
  // ***********************************************************

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld_r <= 1'b0;
      blk_r <= 1'b0;
      lo_r  <= '0;
      seg_r <= '0;
    end else if (rd_en_i) begin
      vld_r <= 1'b1;
      blk_r <= rd_blk_i;
      lo_r  <= row_addr[1:0];
      seg_r <= rd_seg_i;
    end
  end

  // bank data and request regs only move on a read, so the result holds
  always_comb begin
    for (int s = 0; s < `CUR_BLK_BANKS; s++) begin
      if (blk_r) begin
        derot[s] = bank_if.rd_seg[cur_blk_pkg::bank_of_seg(seg_r,
                                  cur_blk_pkg::line_addr_t'(s))];   // line L+s
      end else begin
        derot[s] = bank_if.rd_seg[cur_blk_pkg::bank_of_seg(cur_blk_pkg::bank_idx_t'(s),
                                  cur_blk_pkg::line_addr_t'(lo_r))];
      end
    end
  end

  assign rd_data_o = vld_r ? derot : '0;

endmodule

// ==== verilog/cur_blk_top.sv ====
// ***********************************************************
// top level of the current-block pixel buffer
// pixel stream load side, row and block read side
// ***********************************************************

`timescale 1ns/1ps

module cur_blk_top (
  input  logic               clk,
  input  logic               rst_n_i,

  // load control
  input  logic               start_i,
  output logic               done_o,

  // pixel stream
  output logic               pinc_o,
  input  logic               pvalid_i,
  input  cur_blk_pkg::seg_t  pdata_i,

  // read side
  input  logic               rd_en_i,
  input  logic               rd_blk_i,
  input  logic               rd_chroma_i,
  input  logic [6:0]         rd_line_i,
  input  logic [1:0]         rd_seg_i,
  output cur_blk_pkg::line_t rd_data_o
);

  // ***********************************************************
  // bank bus
  // ***********************************************************

  cur_blk_bank_if bank_if ();

  // ***********************************************************
  // submodules
  // ***********************************************************

  // stream to line writes
  cur_blk_loader i_cur_blk_loader (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .start_i  (start_i),
    .pvalid_i (pvalid_i),
    .pdata_i  (pdata_i),
    .pinc_o   (pinc_o),
    .done_o   (done_o),
    .bank_if  (bank_if.loader)
  );

  // four rotated banks
  cur_blk_line_store i_cur_blk_line_store (
    .clk     (clk),
    .bank_if (bank_if.store)
  );

  cur_blk_read_port i_cur_blk_read_port (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .rd_en_i     (rd_en_i),
    .rd_blk_i    (rd_blk_i),
    .rd_chroma_i (rd_chroma_i),
    .rd_line_i   (rd_line_i),
    .rd_seg_i    (rd_seg_i),
    .rd_data_o   (rd_data_o),
    .bank_if     (bank_if.reader)
  );

endmodule
